//--- cart_macros.svh
`ifndef CART_MACROS_SVH
`define CART_MACROS_SVH

////////////////////
// load stream widths
////////////////////

// byte address of the loader stream
`define CART_ADDR_W 25
// one loader word
`define CART_DATA_W 16
// menu index width
`define CART_INDEX_W 8
// cheat code payload, clock bit not counted
`define CART_CODE_W 128

// loader index that carries cheat codes
`define CART_CODE_INDEX 8'hFF

////////////////////
// cartridge header offsets
////////////////////

// product id words, first and last
`define CART_HDR_ID_FIRST 'h182
`define CART_HDR_ID_LAST 'h18A
// id is complete once this word is written
`define CART_HDR_ID_CHECK 'h18C
// two region words, two letters each
`define CART_HDR_REGION_A 'h1F0
`define CART_HDR_REGION_B 'h1F2
// end of the header area
`define CART_HDR_END 'h200

// sensor delay when the cart has no gun entry
`define CART_GUN_DELAY_DEFAULT 8'd44

`endif

//--- cart_pkg.sv
`default_nettype none

package cart_pkg;

	////////////////////
	// compatibility quirks
	////////////////////

	// bit positions in the quirk vector
	typedef enum int unsigned {
		QUIRK_SRAM   = 0,
		QUIRK_EEPROM = 1,
		QUIRK_FIFO   = 2,
		QUIRK_NORAM  = 3,
		QUIRK_PIER   = 4,
		QUIRK_SVP    = 5,
		QUIRK_FMBUSY = 6,
		QUIRK_SCHAN  = 7
	} quirk_e;

	localparam int QUIRK_N = 8;

	////////////////////
	// header content
	////////////////////

	// region letters with their own flag, ascii codes
	typedef enum logic [7:0] {
		REGION_J = 8'h4A,
		REGION_U = 8'h55
	} region_e;

	// 8 ascii characters, first character in the top byte
	typedef logic [63:0] cart_id_t;

	// lightgun entry of the lookup table
	typedef struct packed {
		logic       gun_type;
		logic [7:0] sensor_delay;
	} gun_cfg_t;

endpackage

`default_nettype wire

//--- load_pkg.sv
`default_nettype none

package load_pkg;

	// where the current loader stream goes
	typedef enum logic [1:0] {
		LOAD_IDLE = 2'd0,
		LOAD_CART = 2'd1,
		LOAD_CODE = 2'd2
	} load_target_e;

	// byte offsets of the eight words of one cheat code
	// lo word first, values big endian inside the code
	typedef enum logic [3:0] {
		SLOT_FLAGS_LO = 4'd0,
		SLOT_FLAGS_HI = 4'd2,
		SLOT_ADDR_LO  = 4'd4,
		SLOT_ADDR_HI  = 4'd6,
		SLOT_CMP_LO   = 4'd8,
		SLOT_CMP_HI   = 4'd10,
		SLOT_REPL_LO  = 4'd12,
		SLOT_REPL_HI  = 4'd14
	} code_slot_e;

endpackage

`default_nettype wire

//--- rom_write_bridge.sv
`default_nettype none

`include "cart_macros.svh"

module rom_write_bridge (
	input  wire                       clk_sys,
	input  wire                       arst_n,
	input  load_pkg::load_target_e    load_target,
	input  wire  [`CART_ADDR_W-1:0]   load_addr,
	input  wire  [`CART_DATA_W-1:0]   load_data,
	input  wire                       load_wr,
	input  wire                       ram_ack,
	output logic                      ram_req,
	output logic [`CART_ADDR_W-1:0]   ram_addr,
	output logic [`CART_DATA_W-1:0]   ram_data,
	output logic                      load_wait
);

	// only cart words go to rom memory
	logic cart_wr;
	// memory has answered the last toggle
	logic ack_match;

	assign cart_wr = load_wr && (load_target == load_pkg::LOAD_CART);
	assign ack_match = (ram_req == ram_ack);

	////////////////////
	// request toggle
	////////////////////

	// one flip per word, memory copies req into ack when done
	// wait goes up with the flip and drops the cycle after ack matches
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ram_req <= 1'b0;
			load_wait <= 1'b0;
		end else if (cart_wr) begin
			ram_req <= ~ram_req;
			load_wait <= 1'b1;
		end else if (load_wait && ack_match) begin
			load_wait <= 1'b0;
		end
	end

	////////////////////
	// address and data
	////////////////////

	// held stable while the request is open
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			ram_addr <= load_addr;
			// loader word is little endian, rom memory wants it swapped
			ram_data <= {load_data[7:0], load_data[15:8]};
		end
	end

endmodule

`default_nettype wire

//--- cheat_code_loader.sv
`default_nettype none

`include "cart_macros.svh"

module cheat_code_loader (
	input  wire                       clk_sys,
	input  wire                       arst_n,
	input  load_pkg::load_target_e    load_target,
	input  wire  [`CART_ADDR_W-1:0]   load_addr,
	input  wire  [`CART_DATA_W-1:0]   load_data,
	input  wire                       load_wr,
	output logic [`CART_CODE_W-1:0]   cheat_code,
	output logic                      cheat_strobe,
	output logic                      cheat_reset
);

	// write aimed at the cheat download
	logic code_wr;
	// word position inside one code
	load_pkg::code_slot_e slot;

	assign code_wr = load_wr && (load_target == load_pkg::LOAD_CODE);
	assign slot = load_pkg::code_slot_e'(load_addr[3:0]);

	////////////////////
	// code word assembly
	////////////////////

	// flags [127:96], address [95:64], compare [63:32], replace [31:0]
	// odd offsets hit no slot and are dropped
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (slot)
				load_pkg::SLOT_FLAGS_LO: cheat_code[111:96] <= load_data;
				load_pkg::SLOT_FLAGS_HI: cheat_code[127:112] <= load_data;
				load_pkg::SLOT_ADDR_LO:  cheat_code[79:64] <= load_data;
				load_pkg::SLOT_ADDR_HI:  cheat_code[95:80] <= load_data;
				load_pkg::SLOT_CMP_LO:   cheat_code[47:32] <= load_data;
				load_pkg::SLOT_CMP_HI:   cheat_code[63:48] <= load_data;
				load_pkg::SLOT_REPL_LO:  cheat_code[15:0] <= load_data;
				load_pkg::SLOT_REPL_HI:  cheat_code[31:16] <= load_data;
				default: ;
			endcase
		end
	end

	////////////////////
	// strobes
	////////////////////

	// replace high is the last word, the code is whole one cycle later
	// offset 0 of the whole download clears the code list
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cheat_strobe <= 1'b0;
			cheat_reset <= 1'b0;
		end else begin
			cheat_strobe <= code_wr && (slot == load_pkg::SLOT_REPL_HI);
			cheat_reset <= code_wr && (load_addr == '0);
		end
	end

endmodule

`default_nettype wire

//--- cart_header_parser.sv
`default_nettype none

`include "cart_macros.svh"

module cart_header_parser (
	input  wire                            clk_sys,
	input  wire                            arst_n,
	input  load_pkg::load_target_e         load_target,
	input  wire  [`CART_ADDR_W-1:0]        load_addr,
	input  wire  [`CART_DATA_W-1:0]        load_data,
	input  wire                            load_wr,
	output logic                           region_j,
	output logic                           region_u,
	output logic                           region_e,
	output logic                           hdr_ready,
	output logic [cart_pkg::QUIRK_N-1:0]   quirks,
	output logic                           gun_type,
	output logic [7:0]                     gun_sensor_delay
);

	typedef enum logic {
		ST_IDLE,
		ST_LOAD
	} state_e;

	state_e state;
	logic is_cart;
	logic cart_wr;
	// edges of a cart download
	logic dl_start;
	logic dl_end;
	cart_pkg::cart_id_t cart_id;

	// one header byte, bits are {j, u, e}
	function automatic logic [2:0] region_hit(input logic [7:0] c);
		if (c == cart_pkg::REGION_J)
			return 3'b100;
		else if (c == cart_pkg::REGION_U)
			return 3'b010;
		else if (c >= "0" && c <= "Z")
			return 3'b001;
		else
			return 3'b000;
	endfunction

	// short list, one or two ids per quirk
	function automatic logic [cart_pkg::QUIRK_N-1:0] quirk_lookup(input cart_pkg::cart_id_t id);
		logic [cart_pkg::QUIRK_N-1:0] q;
		q = '0;
		case (id)
			"T-081276", "T-81406 ": q[cart_pkg::QUIRK_SRAM] = 1'b1;
			"MK-1215 ", "G-4060  ": q[cart_pkg::QUIRK_EEPROM] = 1'b1;
			"T-113016": q[cart_pkg::QUIRK_NORAM] = 1'b1;
			"T-89016 ": q[cart_pkg::QUIRK_FIFO] = 1'b1;
			"T-574023", "T-574013": q[cart_pkg::QUIRK_PIER] = 1'b1;
			"MK-1229 ", "G-7001  ": q[cart_pkg::QUIRK_SVP] = 1'b1;
			"T-35036 ", "T-25073 ": q[cart_pkg::QUIRK_FMBUSY] = 1'b1;
			"T-68???-": q[cart_pkg::QUIRK_SCHAN] = 1'b1;
			default: ;
		endcase
		return q;
	endfunction

	// gun type and sensor delay for the lightgun titles
	function automatic cart_pkg::gun_cfg_t gun_lookup(input cart_pkg::cart_id_t id);
		case (id)
			"MK-1533 ": return '{gun_type: 1'b0, sensor_delay: 8'd100};
			"T-95096-": return '{gun_type: 1'b1, sensor_delay: 8'd52};
			"T-95136-": return '{gun_type: 1'b1, sensor_delay: 8'd30};
			"MK-1658 ": return '{gun_type: 1'b0, sensor_delay: 8'd120};
			"T-081156": return '{gun_type: 1'b0, sensor_delay: 8'd126};
			default: return '{gun_type: 1'b0, sensor_delay: `CART_GUN_DELAY_DEFAULT};
		endcase
	endfunction

	assign is_cart = (load_target == load_pkg::LOAD_CART);
	assign cart_wr = load_wr && is_cart;
	assign dl_start = (state == ST_IDLE) && is_cart;
	assign dl_end = (state == ST_LOAD) && !is_cart;

	////////////////////
	// product id capture
	////////////////////

	// id starts at the odd byte of the first word
	// even byte of each word sits in the low half
	always_ff @(posedge clk_sys) begin
		if (cart_wr) begin
			case (load_addr)
				`CART_HDR_ID_FIRST:       cart_id[63:56] <= load_data[15:8];
				`CART_HDR_ID_FIRST + 'h2: cart_id[55:40] <= {load_data[7:0], load_data[15:8]};
				`CART_HDR_ID_FIRST + 'h4: cart_id[39:24] <= {load_data[7:0], load_data[15:8]};
				`CART_HDR_ID_FIRST + 'h6: cart_id[23:8] <= {load_data[7:0], load_data[15:8]};
				`CART_HDR_ID_LAST:        cart_id[7:0] <= load_data[7:0];
				default: ;
			endcase
		end
	end

	////////////////////
	// flags and lookups
	////////////////////

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_IDLE;
			{region_j, region_u, region_e} <= 3'b000;
			hdr_ready <= 1'b0;
			quirks <= '0;
			gun_type <= 1'b0;
			gun_sensor_delay <= `CART_GUN_DELAY_DEFAULT;
		end else begin
			state <= is_cart ? ST_LOAD : ST_IDLE;
			// fresh cart, forget the old header
			if (dl_start) begin
				{region_j, region_u, region_e} <= 3'b000;
				quirks <= '0;
			end
			if (dl_end)
				hdr_ready <= 1'b0;
			if (cart_wr) begin
				// both letters of a region word count
				if (load_addr == `CART_HDR_REGION_A || load_addr == `CART_HDR_REGION_B)
					{region_j, region_u, region_e} <= {region_j, region_u, region_e}
						| region_hit(load_data[7:0]) | region_hit(load_data[15:8]);
				if (load_addr == `CART_HDR_ID_CHECK) begin
					quirks <= quirk_lookup(cart_id);
					{gun_type, gun_sensor_delay} <= gun_lookup(cart_id);
				end
				if (load_addr == `CART_HDR_END)
					hdr_ready <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- cart_load_top.sv
`default_nettype none

`include "cart_macros.svh"

module cart_load_top (
	input  wire                            clk_sys,
	input  wire                            arst_n,
	input  wire                            load_active,
	input  wire  [`CART_INDEX_W-1:0]       load_index,
	input  wire  [`CART_ADDR_W-1:0]        load_addr,
	input  wire  [`CART_DATA_W-1:0]        load_data,
	input  wire                            load_wr,
	input  wire                            ram_ack,
	output logic                           ram_req,
	output logic [`CART_ADDR_W-1:0]        ram_addr,
	output logic [`CART_DATA_W-1:0]        ram_data,
	output logic                           load_wait,
	output logic [`CART_CODE_W-1:0]        cheat_code,
	output logic                           cheat_strobe,
	output logic                           cheat_reset,
	output logic                           region_j,
	output logic                           region_u,
	output logic                           region_e,
	output logic                           hdr_ready,
	output logic [cart_pkg::QUIRK_N-1:0]   quirks,
	output logic                           gun_type,
	output logic [7:0]                     gun_sensor_delay
);

	load_pkg::load_target_e load_target;

	// all ones index is the cheat download, anything else is a cartridge
	always_comb begin
		if (load_active && load_index == `CART_CODE_INDEX)
			load_target = load_pkg::LOAD_CODE;
		else if (load_active)
			load_target = load_pkg::LOAD_CART;
		else
			load_target = load_pkg::LOAD_IDLE;
	end

	////////////////////
	// units
	////////////////////

	rom_write_bridge u_bridge (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.load_target (load_target),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.load_wr     (load_wr),
		.ram_ack     (ram_ack),
		.ram_req     (ram_req),
		.ram_addr    (ram_addr),
		.ram_data    (ram_data),
		.load_wait   (load_wait)
	);

	cheat_code_loader u_cheat (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.load_target  (load_target),
		.load_addr    (load_addr),
		.load_data    (load_data),
		.load_wr      (load_wr),
		.cheat_code   (cheat_code),
		.cheat_strobe (cheat_strobe),
		.cheat_reset  (cheat_reset)
	);

	// header parser sees every cart word, same as the bridge
	cart_header_parser u_header (
		.clk_sys          (clk_sys),
		.arst_n           (arst_n),
		.load_target      (load_target),
		.load_addr        (load_addr),
		.load_data        (load_data),
		.load_wr          (load_wr),
		.region_j         (region_j),
		.region_u         (region_u),
		.region_e         (region_e),
		.hdr_ready        (hdr_ready),
		.quirks           (quirks),
		.gun_type         (gun_type),
		.gun_sensor_delay (gun_sensor_delay)
	);

endmodule

`default_nettype wire

//--- tb_cart_load_assert.sv
`default_nettype none

`include "cart_macros.svh"

module tb_cart_load_assert (
	input wire                     clk_sys,
	input wire                     arst_n,
	input wire                     load_active,
	input wire [`CART_INDEX_W-1:0] load_index,
	input wire [`CART_ADDR_W-1:0]  load_addr,
	input wire                     load_wr,
	input wire                     ram_ack,
	input wire                     ram_req,
	input wire                     load_wait,
	input wire                     cheat_strobe,
	input wire                     hdr_ready
);

	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;
	// cart stream selected, and a word on it
	logic cart_on;
	logic cart_wr;
	// last word of one cheat code
	logic repl_hi_wr;

	assign cart_on = load_active && (load_index != `CART_CODE_INDEX);
	assign cart_wr = load_wr && cart_on;
	assign repl_hi_wr = load_wr && load_active && (load_index == `CART_CODE_INDEX)
		&& (load_addr[3:0] == load_pkg::SLOT_REPL_HI);

	////////////////////
	// rom handshake
	////////////////////

	// cart word flips the request and raises wait on the next edge
	a_req_toggle: assert property (@(posedge clk_sys) disable iff (!arst_n)
		cart_wr |=> (ram_req != $past(ram_req)) && load_wait)
		else begin
			fail_count++;
			$error("ram_req did not toggle or load_wait stayed low after a cart write");
		end

	// nothing else may flip it, code words included
	a_req_quiet: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!cart_wr |=> ram_req == $past(ram_req))
		else begin
			fail_count++;
			$error("ram_req toggled without a cart write");
		end

	a_no_wr_in_wait: assert property (@(posedge clk_sys) disable iff (!arst_n)
		load_wait |-> !load_wr)
		else begin
			fail_count++;
			$error("load_wr strobed while load_wait was high");
		end

	// wait ends one edge after the ack toggle matched
	a_wait_end: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$fell(load_wait) |-> $past(ram_ack == ram_req))
		else begin
			fail_count++;
			$error("load_wait fell before the memory acknowledged");
		end

	////////////////////
	// cheat strobe and header
	////////////////////

	a_strobe: assert property (@(posedge clk_sys) disable iff (!arst_n)
		repl_hi_wr |=> cheat_strobe)
		else begin
			fail_count++;
			$error("cheat_strobe missing after the replace high word");
		end

	a_strobe_only: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!repl_hi_wr |=> !cheat_strobe)
		else begin
			fail_count++;
			$error("cheat_strobe pulsed without a replace high word");
		end

	a_hdr_end: assert property (@(posedge clk_sys) disable iff (!arst_n)
		cart_wr && (load_addr == 25'(`CART_HDR_END)) |=> hdr_ready)
		else begin
			fail_count++;
			$error("hdr_ready did not rise after the header end word");
		end

	a_hdr_drop: assert property (@(posedge clk_sys) disable iff (!arst_n)
		hdr_ready && !cart_on |=> !hdr_ready)
		else begin
			fail_count++;
			$error("hdr_ready stayed high after the cart download ended");
		end

endmodule

`default_nettype wire

//--- tb_cart_load.sv
`default_nettype none

`include "cart_macros.svh"

module tb_cart_load;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int ADDR_W = `CART_ADDR_W;
	// 5 cart downloads of 13 words, 2 cheat codes of 8 words
	localparam int TEST_WRITES = 5 * 13 + 16;
	localparam int WATCHDOG_CYCLES = 16 + TEST_WRITES * 8 + 500;

	logic clk_sys = 1'b0;
	logic arst_n;
	logic load_active;
	logic [`CART_INDEX_W-1:0] load_index;
	logic [`CART_ADDR_W-1:0] load_addr;
	logic [`CART_DATA_W-1:0] load_data;
	logic load_wr;
	logic ram_ack;
	logic ram_req;
	logic [`CART_ADDR_W-1:0] ram_addr;
	logic [`CART_DATA_W-1:0] ram_data;
	logic load_wait;
	logic [`CART_CODE_W-1:0] cheat_code;
	logic cheat_strobe;
	logic cheat_reset;
	logic region_j;
	logic region_u;
	logic region_e;
	logic hdr_ready;
	logic [cart_pkg::QUIRK_N-1:0] quirks;
	logic gun_type;
	logic [7:0] gun_sensor_delay;

	int errors = 0;
	int model_errors = 0;
	int strobe_count = 0;
	int reset_count = 0;
	// separate streams so the two processes never share a state
	logic [15:0] data_lfsr = 16'd72;
	logic [15:0] ack_lfsr = 16'd72;
	// cart words still owed to the rom memory
	logic [`CART_ADDR_W-1:0] exp_addr_q[$];
	logic [`CART_DATA_W-1:0] exp_data_q[$];

	always #10 clk_sys = ~clk_sys;

	cart_load_top uut (.*);

	bind cart_load_top tb_cart_load_assert u_protocol (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.load_active  (load_active),
		.load_index   (load_index),
		.load_addr    (load_addr),
		.load_wr      (load_wr),
		.ram_ack      (ram_ack),
		.ram_req      (ram_req),
		.load_wait    (load_wait),
		.cheat_strobe (cheat_strobe),
		.hdr_ready    (hdr_ready)
	);

	// pulses seen mid cycle
	always @(negedge clk_sys) begin
		if (cheat_strobe)
			strobe_count++;
		if (cheat_reset)
			reset_count++;
	end

	////////////////////
	// helpers
	////////////////////

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(inout logic [15:0] state, input int n, output logic [15:0] value);
		value = '0;
		for (int i = 0; i < n; i++) begin
			state = lfsr_step(state);
			value = {value[14:0], state[0]};
		end
	endtask

	function automatic logic [cart_pkg::QUIRK_N-1:0] quirk_mask(input cart_pkg::quirk_e k);
		return {{(cart_pkg::QUIRK_N - 1){1'b0}}, 1'b1} << k;
	endfunction

	task automatic check_value(input string name, input logic [127:0] got,
			input logic [127:0] expected);
		if (got !== expected) begin
			errors++;
			$display("FAILED at %0t: %s expected %0h got %0h", $time, name, expected, got);
		end
	endtask

	// one word, held back while the bridge waits on the memory
	task automatic write_word(input logic [`CART_ADDR_W-1:0] addr,
			input logic [`CART_DATA_W-1:0] data);
		while (load_wait) begin
			@(posedge clk_sys);
			#2;
		end
		// rom memory gets cart words with the bytes swapped
		if (load_active && load_index != `CART_CODE_INDEX) begin
			exp_addr_q.push_back(addr);
			exp_data_q.push_back({data[7:0], data[15:8]});
		end
		load_addr = addr;
		load_data = data;
		load_wr = 1'b1;
		@(posedge clk_sys);
		#2;
		load_wr = 1'b0;
	endtask

	// id text lives at bytes 0x183 to 0x18A, even byte in the low half of a word
	task automatic write_id(input logic [63:0] id);
		write_word(ADDR_W'(`CART_HDR_ID_FIRST), {id[63:56], 8'h20});
		write_word(ADDR_W'(`CART_HDR_ID_FIRST + 'h2), {id[47:40], id[55:48]});
		write_word(ADDR_W'(`CART_HDR_ID_FIRST + 'h4), {id[31:24], id[39:32]});
		write_word(ADDR_W'(`CART_HDR_ID_FIRST + 'h6), {id[15:8], id[23:16]});
		write_word(ADDR_W'(`CART_HDR_ID_LAST), {8'h20, id[7:0]});
	endtask

	// flags, address, compare, replace from the top down, low word first
	task automatic load_code(input logic [`CART_ADDR_W-1:0] base,
			input logic [`CART_CODE_W-1:0] code);
		write_word(base | ADDR_W'(load_pkg::SLOT_FLAGS_LO), code[111:96]);
		write_word(base | ADDR_W'(load_pkg::SLOT_FLAGS_HI), code[127:112]);
		write_word(base | ADDR_W'(load_pkg::SLOT_ADDR_LO), code[79:64]);
		write_word(base | ADDR_W'(load_pkg::SLOT_ADDR_HI), code[95:80]);
		write_word(base | ADDR_W'(load_pkg::SLOT_CMP_LO), code[47:32]);
		write_word(base | ADDR_W'(load_pkg::SLOT_CMP_HI), code[63:48]);
		write_word(base | ADDR_W'(load_pkg::SLOT_REPL_LO), code[15:0]);
		write_word(base | ADDR_W'(load_pkg::SLOT_REPL_HI), code[31:16]);
	endtask

	// exp_region is {j, u, e}
	task automatic cart_download(input logic [63:0] id, input logic [15:0] region_a,
			input logic [15:0] region_b, input logic [2:0] exp_region,
			input logic [cart_pkg::QUIRK_N-1:0] exp_quirks, input logic exp_gun,
			input logic [7:0] exp_delay);
		logic [15:0] w;
		load_index = 8'h00;
		load_active = 1'b1;
		@(posedge clk_sys);
		#2;
		// fresh download, old header forgotten
		check_value("region flags", 128'({region_j, region_u, region_e}), 128'd0);
		check_value("quirks", 128'(quirks), 128'd0);
		// a few rom body words ahead of the header
		for (int a = 0; a < 8; a += 2) begin
			take_bits(data_lfsr, 16, w);
			write_word(ADDR_W'(a), w);
		end
		write_id(id);
		write_word(ADDR_W'(`CART_HDR_ID_CHECK), 16'h2020);
		write_word(ADDR_W'(`CART_HDR_REGION_A), region_a);
		write_word(ADDR_W'(`CART_HDR_REGION_B), region_b);
		write_word(ADDR_W'(`CART_HDR_END), 16'h0000);
		while (load_wait) begin
			@(posedge clk_sys);
			#2;
		end
		check_value("hdr_ready", 128'(hdr_ready), 128'd1);
		check_value("region flags", 128'({region_j, region_u, region_e}), 128'(exp_region));
		check_value("quirks", 128'(quirks), 128'(exp_quirks));
		check_value("gun_type", 128'(gun_type), 128'(exp_gun));
		check_value("gun_sensor_delay", 128'(gun_sensor_delay), 128'(exp_delay));
		load_active = 1'b0;
		@(posedge clk_sys);
		#2;
		check_value("hdr_ready", 128'(hdr_ready), 128'd0);
	endtask

	////////////////////
	// rom memory model
	////////////////////

	// answers each toggle after 0 to 7 cycles and checks the presented word
	initial begin : rom_memory
		logic [15:0] delay;
		logic [`CART_ADDR_W-1:0] exp_addr;
		logic [`CART_DATA_W-1:0] exp_data;
		ram_ack = 1'b0;
		forever begin
			@(posedge clk_sys);
			#2;
			if (ram_req !== ram_ack) begin
				take_bits(ack_lfsr, 3, delay);
				repeat (delay) begin
					@(posedge clk_sys);
					#2;
				end
				if (exp_addr_q.size() == 0) begin
					model_errors++;
					$display("rom request at %0t with no cart write pending", $time);
				end else begin
					exp_addr = exp_addr_q.pop_front();
					exp_data = exp_data_q.pop_front();
					if (ram_addr !== exp_addr) begin
						model_errors++;
						$display("FAILED at %0t: ram_addr expected %0h got %0h",
							$time, exp_addr, ram_addr);
					end
					if (ram_data !== exp_data) begin
						model_errors++;
						$display("FAILED at %0t: ram_data expected %0h got %0h",
							$time, exp_data, ram_data);
					end
				end
				ram_ack = ram_req;
			end
		end
	end

	////////////////////
	// watchdog
	////////////////////

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_sys);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("%0d value errors, %0d memory errors, %0d assertion errors",
			errors, model_errors, uut.u_protocol.fail_count);
		$display("SOME TESTS FAILED");
		$finish;
	end

	////////////////////
	// main sequence
	////////////////////

	initial begin
		logic [15:0] w;
		logic [127:0] code_a;
		logic [127:0] code_b;
		arst_n = 1'b0;
		load_active = 1'b0;
		load_index = '0;
		load_addr = '0;
		load_data = '0;
		load_wr = 1'b0;
		repeat (16) @(posedge clk_sys);
		#2;
		arst_n = 1'b1;

		// reset values
		check_value("ram_req", 128'(ram_req), 128'd0);
		check_value("load_wait", 128'(load_wait), 128'd0);
		check_value("cheat_strobe", 128'(cheat_strobe), 128'd0);
		check_value("cheat_reset", 128'(cheat_reset), 128'd0);
		check_value("region flags", 128'({region_j, region_u, region_e}), 128'd0);
		check_value("hdr_ready", 128'(hdr_ready), 128'd0);
		check_value("quirks", 128'(quirks), 128'd0);
		check_value("gun_type", 128'(gun_type), 128'd0);
		check_value("gun_sensor_delay", 128'(gun_sensor_delay), 128'd44);

		// two random cheat codes, the first one starts at offset 0
		code_a = '0;
		code_b = '0;
		for (int i = 0; i < 8; i++) begin
			take_bits(data_lfsr, 16, w);
			code_a = {code_a[111:0], w};
			take_bits(data_lfsr, 16, w);
			code_b = {code_b[111:0], w};
		end
		load_index = `CART_CODE_INDEX;
		load_active = 1'b1;
		@(posedge clk_sys);
		#2;
		load_code(ADDR_W'('h00), code_a);
		check_value("cheat_code", cheat_code, code_a);
		load_code(ADDR_W'('h10), code_b);
		check_value("cheat_code", cheat_code, code_b);
		load_active = 1'b0;
		@(posedge clk_sys);
		#2;
		check_value("cheat_strobe pulses", 128'(strobe_count), 128'd2);
		check_value("cheat_reset pulses", 128'(reset_count), 128'd1);

		// JU region, fifo title
		cart_download("T-89016 ", 16'h554A, 16'h2020, 3'b110,
			quirk_mask(cart_pkg::QUIRK_FIFO), 1'b0, 8'd44);
		// digit in the second region word, svp title
		cart_download("MK-1229 ", 16'h2020, 16'h2034, 3'b001,
			quirk_mask(cart_pkg::QUIRK_SVP), 1'b0, 8'd44);
		// lightgun titles
		cart_download("T-95096-", 16'h2020, 16'h2020, 3'b000, '0, 1'b1, 8'd52);
		cart_download("MK-1533 ", 16'h2020, 16'h2020, 3'b000, '0, 1'b0, 8'd100);
		// id found in neither table
		cart_download("ZZ-9999 ", 16'h2020, 16'h2020, 3'b000, '0, 1'b0, 8'd44);

		check_value("pending rom writes", 128'(exp_addr_q.size()), 128'd0);

		$display("%0d value errors, %0d memory errors, %0d assertion errors",
			errors, model_errors, uut.u_protocol.fail_count);
		if (errors + model_errors + uut.u_protocol.fail_count == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
cart_pkg.sv
load_pkg.sv
rom_write_bridge.sv
cheat_code_loader.sv
cart_header_parser.sv
cart_load_top.sv
tb_cart_load_assert.sv
tb_cart_load.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS ?= --binary --timing --assert --timescale 1ns/100ps -j 0
TOP ?= tb_cart_load
FILELIST ?= tb.f
RUN_FLAGS ?= +verilator+error+limit+1000
PASS_MSG = ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	out="$$(./obj_dir/V$(TOP) $(RUN_FLAGS))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
